// ==== sim.f ====
verilog/cps_pkg.sv
verilog/cps_vtimer.sv
verilog/cps_rom_slot.sv
verilog/cps_bank_arb.sv
verilog/cps_gfx_fetch.sv
verilog/cps_game.sv
tb/cps_sdram_model.sv
tb/tb_cps_game.sv

// ==== Makefile ====
# Verilator build and run for the CPS-style game testbench

VERILATOR ?= verilator
TOP       ?= tb_cps_game
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/tb_cps_game.sv ====
// Testbench for the CPS-style game top
// Checks reset, raster timing, tile pixels and main ROM reads against an SDRAM model
`timescale 1ns/1ps
`default_nettype none

module tb_cps_game;

import cps_pkg::*;

localparam int        H_ACTIVE       = 32;
localparam int        H_TOTAL        = 48;
localparam int        V_ACTIVE       = 8;
localparam int        V_TOTAL        = 12;
localparam rom_addr_t GFX_BASE       = 22'h10_0000;
localparam int        CLK_PERIOD     = 100;
localparam int        IN_DELAY       = 10;
localparam int        RESET_CYCLES   = 16;
localparam int        FRAME_CYCLES   = H_TOTAL * V_TOTAL * 8;
localparam int        RUN_CYCLES     = RESET_CYCLES + 2 * FRAME_CYCLES;
// Two frames plus a 30 % margin
localparam int        TIMEOUT_CYCLES = RUN_CYCLES * 13 / 10;
localparam int        NUM_READS      = 40;
localparam int        READ_GAP       = 180;

logic              clk;
logic              rst_n;
logic              main_rom_cs;
rom_addr_t         main_rom_addr;
wire main_word_t   main_rom_data;
wire               main_rom_ok, LHBL, LVBL, HS, VS, pxl_cen, pxl2_cen;
wire [7:0]         red, green, blue;
wire rom_addr_t    ba0_addr;
wire               ba_rd, ba_ack, ba_dok, ba_rdy;
wire sdram_word_t  data_read;
int                rd_count;
rom_addr_t         rd_addr;

int        test_err [1:5];
int        cycles = 0;
int        frames, hs_pulses, vs_pulses, cen_gap, p2_count, th, tv;
int        reads_done, reads_active, repeats_done;
logic      reset_done, started, have_main, hs_prev, vs_prev;
rom_addr_t last_main;
logic [31:0] lcg_state;

cps_game #(
    .H_ACTIVE   ( H_ACTIVE  ),
    .H_TOTAL    ( H_TOTAL   ),
    .V_ACTIVE   ( V_ACTIVE  ),
    .V_TOTAL    ( V_TOTAL   ),
    .GFX_BASE   ( GFX_BASE  )
) UUT (
    .clk(clk), .rst_n(rst_n),
    .main_rom_cs(main_rom_cs), .main_rom_addr(main_rom_addr),
    .main_rom_data(main_rom_data), .main_rom_ok(main_rom_ok),
    .red(red), .green(green), .blue(blue),
    .LHBL(LHBL), .LVBL(LVBL), .HS(HS), .VS(VS),
    .pxl_cen(pxl_cen), .pxl2_cen(pxl2_cen),
    .ba0_addr(ba0_addr), .ba_rd(ba_rd), .ba_ack(ba_ack),
    .ba_dok(ba_dok), .ba_rdy(ba_rdy), .data_read(data_read)
);

cps_sdram_model u_sdram (
    .clk(clk), .rst_n(rst_n),
    .ba0_addr(ba0_addr), .ba_rd(ba_rd), .ba_ack(ba_ack),
    .ba_dok(ba_dok), .ba_rdy(ba_rdy), .data_read(data_read),
    .rd_count(rd_count), .rd_addr(rd_addr)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

task automatic report_mismatch(input int test, input string name,
                               input logic [31:0] exp, input logic [31:0] act);
    test_err[test]++;
    $display("** Error at %0t ns: test %0d, %s expected %0h, got %0h",
             $time, test, name, exp, act);
endtask

task automatic report_failure(input int test, input string what);
    test_err[test]++;
    $display("Test %0d failure at %0t ns: %s", test, $time, what);
endtask

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

// SDRAM word: low 16 address bits XOR a fixed key
function automatic logic [15:0] pattern_word(input rom_addr_t a);
    return a[15:0] ^ 16'hA5C3;
endfunction

// Grey level of pixel h on line v, nibble h%8 of the tile word, doubled
function automatic logic [7:0] expected_grey(input int h, input int v);
    rom_addr_t   word_addr;
    rom_addr_t   sdram_addr;
    logic [31:0] tile;
    logic [3:0]  nib;
    word_addr  = GFX_BASE + 22'(v * (H_ACTIVE / 8) + h / 8);
    sdram_addr = {word_addr[20:0], 1'b0};
    tile       = {pattern_word(sdram_addr + 22'd1), pattern_word(sdram_addr)};
    nib        = tile[4 * (h % 8) +: 4];
    return {nib, nib};
endfunction

// Repeat a cached address, then read the other word of its burst
task automatic cache_repeat(input rom_addr_t addr);
    int        fetches;
    rom_addr_t twin;
    fetches = rd_count;
    twin    = addr ^ 22'd1;
    @(posedge clk);
    #IN_DELAY main_rom_addr = addr;
    repeat (8) begin
        @(negedge clk);
        assert (main_rom_ok) else report_failure(5, "main_rom_ok fell on a repeated address");
        if (rd_count != fetches) begin
            assert (rd_addr != {addr[21:1], 1'b0})
                else report_failure(5, "repeated address started a new SDRAM read");
            fetches = rd_count;
        end
    end
    @(posedge clk);
    #IN_DELAY main_rom_addr = twin;
    @(posedge clk);
    @(negedge clk);
    assert (main_rom_ok) else report_failure(5, "main_rom_ok low on the other word of a burst");
    assert (main_rom_data == pattern_word(twin))
        else report_mismatch(5, "main_rom_data", 32'(pattern_word(twin)), 32'(main_rom_data));
    repeats_done++;
endtask

task automatic main_read(input rom_addr_t addr, input logic with_repeat);
    logic new_burst;
    new_burst = !have_main || addr[21:1] != last_main[21:1];
    @(posedge clk);
    #IN_DELAY;
    main_rom_cs   = 1'b1;
    main_rom_addr = addr;
    if (LHBL && LVBL) reads_active++;
    @(negedge clk);
    if (new_burst) begin
        @(negedge clk);
        assert (!main_rom_ok)
            else report_failure(4, "main_rom_ok stayed high after an uncached address");
    end
    while (!main_rom_ok) @(negedge clk);
    assert (main_rom_data == pattern_word(addr))
        else report_mismatch(4, "main_rom_data", 32'(pattern_word(addr)), 32'(main_rom_data));
    reads_done++;
    last_main = addr;
    have_main = 1'b1;
    if (with_repeat) cache_repeat(addr);
endtask

// Reset, raster and pixel checks, once per pixel on its last cycle
always @(negedge clk) begin : monitor
    logic [7:0] exp_grey;
    if (!reset_done) begin
        assert (!ba_rd) else report_mismatch(1, "ba_rd", 0, 32'(ba_rd));
        assert (!main_rom_ok) else report_mismatch(1, "main_rom_ok", 0, 32'(main_rom_ok));
        assert ({red, green, blue} == 24'd0)
            else report_mismatch(1, "red/green/blue", 0, 32'({red, green, blue}));
    end
    if (!rst_n) begin
        th        = 0;
        tv        = 0;
        frames    = 0;
        hs_pulses = 0;
        vs_pulses = 0;
        cen_gap   = 0;
        p2_count  = 0;
        hs_prev   = 1'b0;
        vs_prev   = 1'b0;
        started   = 1'b0;
    end else begin
        cen_gap++;
        if (pxl2_cen) p2_count++;
        if (pxl_cen) begin
            exp_grey = (started && th < H_ACTIVE && tv < V_ACTIVE) ? expected_grey(th, tv) : 8'd0;
            assert (red == exp_grey) else report_mismatch(3, "red", 32'(exp_grey), 32'(red));
            assert (green == exp_grey) else report_mismatch(3, "green", 32'(exp_grey), 32'(green));
            assert (blue == exp_grey) else report_mismatch(3, "blue", 32'(exp_grey), 32'(blue));
            if (started) begin
                assert (cen_gap == 8) else report_mismatch(2, "pxl_cen period", 8, cen_gap);
                // Two half-pixel enables per pixel, the second on the pixel enable
                assert (pxl2_cen) else report_failure(2, "pxl2_cen missing on a pxl_cen cycle");
                assert (p2_count == 2) else report_mismatch(2, "pxl2_cen pulses", 2, p2_count);
                assert (LHBL == (th < H_ACTIVE))
                    else report_mismatch(2, "LHBL", 32'(th < H_ACTIVE), 32'(LHBL));
                assert (LVBL == (tv < V_ACTIVE))
                    else report_mismatch(2, "LVBL", 32'(tv < V_ACTIVE), 32'(LVBL));
                assert (HS == (th >= H_ACTIVE + 4 && th < H_ACTIVE + 8))
                    else report_mismatch(2, "HS", 32'(th >= H_ACTIVE + 4 && th < H_ACTIVE + 8),
                                         32'(HS));
                assert (VS == (tv == V_ACTIVE + 1))
                    else report_mismatch(2, "VS", 32'(tv == V_ACTIVE + 1), 32'(VS));
                if (HS && !hs_prev) hs_pulses++;
                if (VS && !vs_prev) vs_pulses++;
            end
            hs_prev  = HS;
            vs_prev  = VS;
            cen_gap  = 0;
            p2_count = 0;
            th++;
            if (th == H_TOTAL) begin
                th = 0;
                started = 1'b1;
                tv = (tv == V_TOTAL - 1) ? 0 : tv + 1;
                if (tv == 0) frames++;
            end
        end
    end
end

always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: run not finished after %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end
end

initial begin
    int total;
    int failing;
    rst_n         = 1'b0;
    main_rom_cs   = 1'b0;
    main_rom_addr = '0;
    reset_done    = 1'b0;
    have_main     = 1'b0;
    last_main     = '0;
    reads_done    = 0;
    reads_active  = 0;
    repeats_done  = 0;
    foreach (test_err[k]) test_err[k] = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #IN_DELAY rst_n = 1'b1;
    repeat (4) @(posedge clk);
    #IN_DELAY reset_done = 1'b1;
    $display("Test 1 reset state: %0d errors", test_err[1]);

    lcg_state = 32'd59470;
    for (int i = 0; i < NUM_READS; i++) begin
        lcg_state = lcg_step(lcg_state);
        main_read(lcg_state[30:9], i % 5 == 4);
        repeat (READ_GAP) @(posedge clk);
    end
    $display("Test 4 main reads: %0d reads, %0d errors", reads_done, test_err[4]);
    assert (reads_active > 0) else report_failure(5, "no main read was issued during active video");
    $display("Test 5 cache and contention: %0d repeats, %0d reads in active video, %0d errors",
             repeats_done, reads_active, test_err[5]);

    wait (frames >= 2);
    // One HS per line after the first, one VS per frame
    assert (hs_pulses == 2 * V_TOTAL - 1)
        else report_mismatch(2, "HS pulses", 2 * V_TOTAL - 1, hs_pulses);
    assert (vs_pulses == 2) else report_mismatch(2, "VS pulses", 2, vs_pulses);
    $display("Test 2 raster timing: %0d HS and %0d VS pulses, %0d errors",
             hs_pulses, vs_pulses, test_err[2]);
    $display("Test 3 pixel data: %0d frames, %0d errors", frames, test_err[3]);
    total   = 0;
    failing = 0;
    foreach (test_err[k]) begin
        total += test_err[k];
        if (test_err[k] != 0) failing++;
    end
    $display("Summary: 5 tests, %0d failing, %0d errors", failing, total);
    if (total == 0) begin
        $display("Testbench passed");
    end else begin
        $display("Testbench failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== tb/cps_sdram_model.sv ====
// Behavioral SDRAM bank for the game testbench
// Answers two-word bursts with an address-derived pattern after a random latency
`timescale 1ns/1ps
`default_nettype none

module cps_sdram_model #(
    parameter int unsigned SEED = 59470
)(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire cps_pkg::rom_addr_t     ba0_addr,
    input  wire                         ba_rd,
    output logic                        ba_ack,
    output logic                        ba_dok,
    output logic                        ba_rdy,
    output cps_pkg::sdram_word_t        data_read,
    output int                          rd_count,
    output cps_pkg::rom_addr_t          rd_addr
);

import cps_pkg::*;

logic        busy;
logic [4:0]  cnt;
logic [31:0] lcg_state;

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

// Every word holds its own address, scrambled
function automatic sdram_word_t word_at(input rom_addr_t a);
    return a[15:0] ^ 16'hA5C3;
endfunction

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        busy      <= 1'b0;
        cnt       <= 5'd0;
        ba_ack    <= 1'b0;
        ba_dok    <= 1'b0;
        ba_rdy    <= 1'b0;
        data_read <= '0;
        rd_count  <= 0;
        rd_addr   <= '0;
        lcg_state <= SEED;
    end else begin
        ba_ack <= 1'b0;
        ba_dok <= 1'b0;
        ba_rdy <= 1'b0;
        if (!busy && ba_rd) begin
            busy      <= 1'b1;
            ba_ack    <= 1'b1;
            rd_addr   <= ba0_addr;
            rd_count  <= rd_count + 1;
            lcg_state <= lcg_step(lcg_state);
            // 2 to 17 cycles from the ack to the second word
            cnt       <= 5'd1 + 5'(lcg_state[19:16]);
        end else if (busy) begin
            cnt <= cnt - 5'd1;
            if (cnt == 5'd1) begin
                ba_dok    <= 1'b1;
                data_read <= word_at(rd_addr);
            end
            if (cnt == 5'd0) begin
                ba_dok    <= 1'b1;
                ba_rdy    <= 1'b1;
                data_read <= word_at(rd_addr + 22'd1);
                busy      <= 1'b0;
            end
        end
    end
end

endmodule

`default_nettype wire

// ==== verilog/cps_game.sv ====
// CPS-style game top
// Video timer, graphics fetcher and two ROM slots sharing SDRAM bank 0
`timescale 1ns/1ps
`default_nettype none

module cps_game #(
    parameter int H_ACTIVE = 384,
    parameter int H_TOTAL  = 512,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 262,
    parameter cps_pkg::rom_addr_t GFX_BASE = 22'h10_0000
)(
    input  wire                         clk,
    input  wire                         rst_n,
    // Main CPU ROM port
    input  wire                         main_rom_cs,
    input  wire cps_pkg::rom_addr_t     main_rom_addr,
    output wire cps_pkg::main_word_t    main_rom_data,
    output wire                         main_rom_ok,
    // Video
    output wire [7:0]                   red,
    output wire [7:0]                   green,
    output wire [7:0]                   blue,
    output wire                         LHBL,
    output wire                         LVBL,
    output wire                         HS,
    output wire                         VS,
    output wire                         pxl_cen,
    output wire                         pxl2_cen,
    // SDRAM bank 0
    output wire cps_pkg::rom_addr_t     ba0_addr,
    output wire                         ba_rd,
    input  wire                         ba_ack,
    input  wire                         ba_dok,
    input  wire                         ba_rdy,
    input  wire cps_pkg::sdram_word_t   data_read
);

import cps_pkg::*;

wire [8:0]              hdump, vdump;
wire                    gfx_cs, gfx_ok;
wire rom_addr_t         gfx_addr, gfx_req_addr, main_req_addr;
wire gfx_word_t         gfx_data;
wire [NUM_SLOTS-1:0]    req_valid, req_ready, rsp_valid;
wire burst_t            rsp_data;

cps_vtimer #(
    .H_ACTIVE   ( H_ACTIVE      ),
    .H_TOTAL    ( H_TOTAL       ),
    .V_ACTIVE   ( V_ACTIVE      ),
    .V_TOTAL    ( V_TOTAL       )
) u_timer (
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .pxl2_cen   ( pxl2_cen      ),
    .pxl_cen    ( pxl_cen       ),
    .hdump      ( hdump         ),
    .vdump      ( vdump         ),
    .LHBL       ( LHBL          ),
    .LVBL       ( LVBL          ),
    .HS         ( HS            ),
    .VS         ( VS            )
);

cps_gfx_fetch #(
    .H_ACTIVE   ( H_ACTIVE      ),
    .H_TOTAL    ( H_TOTAL       ),
    .V_ACTIVE   ( V_ACTIVE      ),
    .V_TOTAL    ( V_TOTAL       ),
    .GFX_BASE   ( GFX_BASE      )
) u_fetch (
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .pxl_cen    ( pxl_cen       ),
    .hdump      ( hdump         ),
    .vdump      ( vdump         ),
    .LHBL       ( LHBL          ),
    .LVBL       ( LVBL          ),
    .rom_cs     ( gfx_cs        ),
    .rom_addr   ( gfx_addr      ),
    .rom_data   ( gfx_data      ),
    .rom_ok     ( gfx_ok        ),
    .red        ( red           ),
    .green      ( green         ),
    .blue       ( blue          )
);

// Graphics slot, 32-bit tile words
cps_rom_slot #(.data_t(gfx_word_t)) u_gfx_slot (
    .clk        ( clk                   ),
    .rst_n      ( rst_n                 ),
    .cs         ( gfx_cs                ),
    .addr       ( gfx_addr              ),
    .data       ( gfx_data              ),
    .ok         ( gfx_ok                ),
    .req_valid  ( req_valid[SLOT_GFX]   ),
    .req_ready  ( req_ready[SLOT_GFX]   ),
    .req_addr   ( gfx_req_addr          ),
    .rsp_valid  ( rsp_valid[SLOT_GFX]   ),
    .rsp_data   ( rsp_data              )
);

// Main CPU slot, 16-bit words
cps_rom_slot #(.data_t(main_word_t)) u_main_slot (
    .clk        ( clk                   ),
    .rst_n      ( rst_n                 ),
    .cs         ( main_rom_cs           ),
    .addr       ( main_rom_addr         ),
    .data       ( main_rom_data         ),
    .ok         ( main_rom_ok           ),
    .req_valid  ( req_valid[SLOT_MAIN]  ),
    .req_ready  ( req_ready[SLOT_MAIN]  ),
    .req_addr   ( main_req_addr         ),
    .rsp_valid  ( rsp_valid[SLOT_MAIN]  ),
    .rsp_data   ( rsp_data              )
);

cps_bank_arb u_arb (
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .req_valid  ( req_valid     ),
    .req_ready  ( req_ready     ),
    .req_addr0  ( gfx_req_addr  ),
    .req_addr1  ( main_req_addr ),
    .rsp_valid  ( rsp_valid     ),
    .rsp_data   ( rsp_data      ),
    .ba0_addr   ( ba0_addr      ),
    .ba_rd      ( ba_rd         ),
    .ba_ack     ( ba_ack        ),
    .ba_dok     ( ba_dok        ),
    .ba_rdy     ( ba_rdy        ),
    .data_read  ( data_read     )
);

endmodule

`default_nettype wire

// ==== verilog/cps_gfx_fetch.sv ====
// Graphics fetcher
// Prefetches one tile word per 8-pixel group and shifts out grey pixels
`timescale 1ns/1ps
`default_nettype none

module cps_gfx_fetch #(
    parameter int H_ACTIVE = 384,
    parameter int H_TOTAL  = 512,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 262,
    parameter cps_pkg::rom_addr_t GFX_BASE = 22'h10_0000
)(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         pxl_cen,
    input  wire [8:0]                   hdump,
    input  wire [8:0]                   vdump,
    input  wire                         LHBL,
    input  wire                         LVBL,
    output logic                        rom_cs,
    output cps_pkg::rom_addr_t          rom_addr,
    input  wire cps_pkg::gfx_word_t     rom_data,
    input  wire                         rom_ok,
    output logic [7:0]                  red,
    output logic [7:0]                  green,
    output logic [7:0]                  blue
);

import cps_pkg::*;

localparam int GROUPS     = H_TOTAL / 8;
localparam int ACT_GROUPS = H_ACTIVE / 8;

logic [6:0] tgt_grp;
logic [9:0] tgt_line;
logic       grp_end, want;
gfx_word_t  shreg;
logic [3:0] pix;

// Next pixel opens a new group
assign grp_end = pxl_cen && hdump[2:0] == 3'd7;

// Word for the group after the one that starts now
always_comb begin
    tgt_grp  = {1'b0, hdump[8:3]} + 7'd2;
    tgt_line = {1'b0, vdump};
    if (tgt_grp >= 7'(GROUPS)) begin
        tgt_grp  = tgt_grp - 7'(GROUPS);
        tgt_line = (vdump == 9'(V_TOTAL - 1)) ? 10'd0 : tgt_line + 10'd1;
    end
    want = tgt_grp < 7'(ACT_GROUPS) && tgt_line < 10'(V_ACTIVE);
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) rom_cs <= 1'b0;
    else if (grp_end && want) rom_cs <= 1'b1;
    else if (rom_ok) rom_cs <= 1'b0;
end

always_ff @(posedge clk) begin
    if (grp_end && want)
        rom_addr <= GFX_BASE + rom_addr_t'(tgt_line) * rom_addr_t'(ACT_GROUPS)
                  + rom_addr_t'(tgt_grp);
    if (grp_end) begin
        pix   <= rom_data[3:0];
        shreg <= rom_data >> 4;
    end else if (pxl_cen) begin
        pix   <= shreg[3:0];
        shreg <= shreg >> 4;
    end
end

assign red   = (LHBL && LVBL) ? {pix, pix} : 8'd0;
assign green = red;
assign blue  = red;

endmodule

`default_nettype wire

// ==== verilog/cps_bank_arb.sv ====
// SDRAM bank arbiter
// Round-robin grant between ROM slots, one two-word burst at a time
`timescale 1ns/1ps
`default_nettype none

module cps_bank_arb(
    input  wire                             clk,
    input  wire                             rst_n,
    // Slot side
    input  wire [cps_pkg::NUM_SLOTS-1:0]    req_valid,
    output logic [cps_pkg::NUM_SLOTS-1:0]   req_ready,
    input  wire cps_pkg::rom_addr_t         req_addr0,
    input  wire cps_pkg::rom_addr_t         req_addr1,
    output logic [cps_pkg::NUM_SLOTS-1:0]   rsp_valid,
    output cps_pkg::burst_t                 rsp_data,
    // SDRAM bank 0
    output cps_pkg::rom_addr_t              ba0_addr,
    output logic                            ba_rd,
    input  wire                             ba_ack,
    input  wire                             ba_dok,
    input  wire                             ba_rdy,
    input  wire cps_pkg::sdram_word_t       data_read
);

import cps_pkg::*;

typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_DATA, ST_RESP} state_t;

state_t      state;
logic        rr, sel, gnt;
sdram_word_t word_lo;

// Priority slot first, the other one if it is idle
assign sel = req_valid[rr] ? rr : ~rr;

always_comb begin
    req_ready = '0;
    if (state == ST_IDLE) req_ready[sel] = req_valid[sel];
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state     <= ST_IDLE;
        ba_rd     <= 1'b0;
        rr        <= 1'b0;
        gnt       <= 1'b0;
        rsp_valid <= '0;
    end else begin
        rsp_valid <= '0;
        case (state)
            ST_IDLE: if (|req_valid) begin
                gnt   <= sel;
                rr    <= ~sel;
                ba_rd <= 1'b1;
                state <= ST_REQ;
            end
            ST_REQ: if (ba_ack) begin
                ba_rd <= 1'b0;
                state <= ST_DATA;
            end
            ST_DATA: if (ba_rdy) begin
                rsp_valid[gnt] <= 1'b1;
                state          <= ST_RESP;
            end
            default: state <= ST_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == ST_IDLE && |req_valid) ba0_addr <= sel ? req_addr1 : req_addr0;
    if (state == ST_DATA && ba_dok && !ba_rdy) word_lo <= data_read;
    // Second word arrives together with ba_rdy
    if (state == ST_DATA && ba_rdy) rsp_data <= {data_read, word_lo};
end

endmodule

`default_nettype wire

// ==== verilog/cps_rom_slot.sv ====
// ROM slot for one client of the SDRAM bank arbiter
// Keeps the last burst fetched and requests a new one on a miss
`timescale 1ns/1ps
`default_nettype none

module cps_rom_slot #(
    parameter type data_t = cps_pkg::main_word_t
)(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         cs,
    input  wire cps_pkg::rom_addr_t     addr,
    output data_t                       data,
    output logic                        ok,
    // Arbiter side
    output logic                        req_valid,
    input  wire                         req_ready,
    output cps_pkg::rom_addr_t          req_addr,
    input  wire                         rsp_valid,
    input  wire cps_pkg::burst_t        rsp_data
);

import cps_pkg::*;

// A wide client addresses whole bursts, a narrow one SDRAM words
localparam bit WIDE = $bits(data_t) == $bits(burst_t);

rom_addr_t  burst_addr, tag;
burst_t     cache;
logic       cache_vld, pending;
logic       hit, miss_start;

assign burst_addr = WIDE ? {addr[20:0], 1'b0} : {addr[21:1], 1'b0};
assign hit        = cache_vld && tag == burst_addr;
assign miss_start = cs && !hit && !req_valid && !pending;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        ok        <= 1'b0;
        req_valid <= 1'b0;
        pending   <= 1'b0;
        cache_vld <= 1'b0;
    end else begin
        ok <= cs && hit;
        if (req_valid && req_ready) begin
            req_valid <= 1'b0;
            pending   <= 1'b1;
        end else if (miss_start) begin
            req_valid <= 1'b1;
        end
        if (rsp_valid) begin
            pending   <= 1'b0;
            cache_vld <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (miss_start) req_addr <= burst_addr;
    if (rsp_valid) begin
        tag   <= req_addr;
        cache <= rsp_data;
    end
end

generate
    if (WIDE) begin : g_full
        assign data = data_t'(cache);
    end else begin : g_half
        // Odd word sits in the upper half of the burst
        assign data = data_t'(addr[0] ? cache[31:16] : cache[15:0]);
    end
endgenerate

endmodule

`default_nettype wire

// ==== verilog/cps_vtimer.sv ====
// Video timer
// Pixel clock enables, raster counters, blanking and sync
`timescale 1ns/1ps
`default_nettype none

module cps_vtimer #(
    parameter int H_ACTIVE = 384,
    parameter int H_TOTAL  = 512,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 262
)(
    input  wire         clk,
    input  wire         rst_n,
    output logic        pxl2_cen,
    output logic        pxl_cen,
    output logic [8:0]  hdump,
    output logic [8:0]  vdump,
    output logic        LHBL,
    output logic        LVBL,
    output logic        HS,
    output logic        VS
);

localparam logic [8:0] H_LAST  = 9'(H_TOTAL - 1);
localparam logic [8:0] V_LAST  = 9'(V_TOTAL - 1);
localparam logic [8:0] H_ACT   = 9'(H_ACTIVE);
localparam logic [8:0] V_ACT   = 9'(V_ACTIVE);
localparam logic [8:0] HS_START = 9'(H_ACTIVE + 4);
localparam logic [8:0] HS_END   = 9'(H_ACTIVE + 8);
localparam logic [8:0] VS_LINE  = 9'(V_ACTIVE + 1);

logic [2:0] cen_cnt;
logic [8:0] h_next, v_next;

assign h_next = (hdump == H_LAST) ? 9'd0 : hdump + 9'd1;
assign v_next = (vdump == V_LAST) ? 9'd0 : vdump + 9'd1;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        cen_cnt  <= 3'd0;
        pxl2_cen <= 1'b0;
        pxl_cen  <= 1'b0;
        hdump    <= 9'd0;
        vdump    <= 9'd0;
        LHBL     <= 1'b0;
        LVBL     <= 1'b0;
        HS       <= 1'b0;
        VS       <= 1'b0;
    end else begin
        cen_cnt  <= cen_cnt + 3'd1;
        pxl2_cen <= cen_cnt[1:0] == 2'b11;
        pxl_cen  <= cen_cnt == 3'b111;
        if (pxl_cen) begin
            // Flags describe the pixel that hdump moves to
            hdump <= h_next;
            LHBL  <= h_next < H_ACT;
            HS    <= h_next >= HS_START && h_next < HS_END;
            // Vertical flags change only at the line wrap
            if (hdump == H_LAST) begin
                vdump <= v_next;
                LVBL  <= v_next < V_ACT;
                VS    <= v_next == VS_LINE;
            end
        end
    end
end

endmodule

`default_nettype wire

// ==== verilog/cps_pkg.sv ====
// CPS-style game package
// Shared ROM address, SDRAM word and arbiter slot definitions
`default_nettype none

package cps_pkg;

    // SDRAM word address, one bank
    typedef logic [21:0] rom_addr_t;

    typedef logic [15:0] sdram_word_t;

    // Eight 4-bit pixels, pixel 0 in the low nibble
    typedef logic [31:0] gfx_word_t;

    typedef logic [15:0] main_word_t;

    // Two SDRAM words, lower address in the low half
    typedef logic [31:0] burst_t;

    // Arbiter clients
    localparam int NUM_SLOTS = 2;
    localparam int SLOT_GFX  = 0;
    localparam int SLOT_MAIN = 1;

endpackage

`default_nettype wire
